// ==== common/tile_pkg.sv ====
/*
 * shared widths, tile constants and controller step enum
 * for the tiled int8 matrix-multiply engine
 */
package tile_pkg;

  // tile geometry
  localparam int M = 4;         // rows per tile
  localparam int N = 4;         // int8 lanes per word
  localparam int FifoDepth = 2; // result entries in the writer

  typedef logic [31:0] word_t;
  typedef logic [15:0] addr_t;
  typedef logic [7:0] tile_cnt_t;
  typedef logic [1:0] row_cnt_t;
  typedef logic signed [31:0] acc_t;
  typedef logic [4:0] shift_t;

  typedef enum logic [1:0] {
    Idle,
    MatMul,
    Drain
  } step_e;

endpackage

// ==== logic/wb_arbiter.sv ====
/*
 * round-robin Wishbone classic arbiter, several masters onto one port
 */
`timescale 1ns/1ps

module wb_arbiter #(
  parameter int NumMasters = 3
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic            [NumMasters-1:0]    m_cyc_i,
  input  logic            [NumMasters-1:0]    m_stb_i,
  input  logic            [NumMasters-1:0]    m_we_i,
  input  tile_pkg::addr_t [NumMasters-1:0]    m_adr_i,
  input  tile_pkg::word_t [NumMasters-1:0]    m_dat_i,
  output tile_pkg::word_t [NumMasters-1:0]    m_dat_o,
  output logic            [NumMasters-1:0]    m_ack_o,
  output logic                                wb_cyc_o,
  output logic                                wb_stb_o,
  output logic                                wb_we_o,
  output tile_pkg::addr_t                     wb_adr_o,
  output tile_pkg::word_t                     wb_dat_o,
  input  tile_pkg::word_t                     wb_dat_i,
  input  logic                                wb_ack_i
);

  localparam int IdxW = (NumMasters > 1) ? $clog2(NumMasters) : 1;

  logic [IdxW-1:0] gnt_q, gnt_d;
  logic            own_q, own_d;
  logic            bus_cyc;

  assign bus_cyc = own_q && m_cyc_i[gnt_q];

  // pick the next requester after the previous owner
  always_comb begin
    gnt_d = gnt_q;
    own_d = own_q;
    if (!bus_cyc) begin
      own_d = 1'b0;
      for (int i = NumMasters; i >= 1; i--) begin
        if (m_cyc_i[(int'(gnt_q) + i) % NumMasters]) begin
          gnt_d = IdxW'((int'(gnt_q) + i) % NumMasters); // nearest one wins
          own_d = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q <= '0;
      own_q <= 1'b0;
    end else begin
      gnt_q <= gnt_d;
      own_q <= own_d;
    end
  end

  assign wb_cyc_o = bus_cyc;
  assign wb_stb_o = own_q && m_stb_i[gnt_q];
  assign wb_we_o  = own_q && m_we_i[gnt_q];
  assign wb_adr_o = m_adr_i[gnt_q];
  assign wb_dat_o = m_dat_i[gnt_q];

  always_comb begin
    for (int i = 0; i < NumMasters; i++) begin
      m_ack_o[i] = wb_ack_i && bus_cyc && (int'(gnt_q) == i); // owner only
      m_dat_o[i] = wb_dat_i;
    end
  end

endmodule

// ==== fetch/tile_reader.sv ====
/*
 * Wishbone reader fetching a run of strided words per request
 */
`timescale 1ns/1ps

module tile_reader #(
  parameter int WORDS = 1
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         req_i,
  input  tile_pkg::addr_t              addr_i,
  input  tile_pkg::tile_cnt_t          stride_i,
  input  logic                         pop_i,
  output logic                         ready_o,
  output logic                         data_valid_o,
  output tile_pkg::word_t [WORDS-1:0]  data_o,
  output logic                         wb_cyc_o,
  output logic                         wb_stb_o,
  output tile_pkg::addr_t              wb_adr_o,
  input  tile_pkg::word_t              wb_dat_i,
  input  logic                         wb_ack_i
);

  localparam int IdxW = $clog2(WORDS + 1);

  logic [IdxW-1:0]             idx_q;
  logic                        busy_q;
  logic                        cyc_q;
  logic                        valid_q;
  tile_pkg::addr_t             adr_q;
  tile_pkg::word_t [WORDS-1:0] data_q;
  logic                        start;
  logic                        hit;

  assign ready_o = !busy_q && !valid_q;
  assign start   = req_i && ready_o;
  assign hit     = cyc_q && wb_ack_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q   <= '0;
      busy_q  <= 1'b0;
      cyc_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      if (start) begin
        busy_q <= 1'b1;
        cyc_q  <= 1'b1;
        idx_q  <= '0;
      end else if (hit) begin
        cyc_q <= 1'b0; // one idle cycle between transfers
        if (idx_q == IdxW'(WORDS - 1)) begin
          busy_q  <= 1'b0;
          valid_q <= 1'b1;
        end else begin
          idx_q <= idx_q + 1'b1;
        end
      end else if (busy_q && !cyc_q) begin
        cyc_q <= 1'b1;
      end
      if (pop_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      adr_q <= addr_i;
    end else if (hit) begin
      data_q[idx_q] <= wb_dat_i;
      adr_q         <= adr_q + tile_pkg::addr_t'(stride_i);
    end
  end

  assign data_valid_o = valid_q;
  assign data_o       = data_q;
  assign wb_cyc_o     = cyc_q;
  assign wb_stb_o     = cyc_q;
  assign wb_adr_o     = adr_q;

endmodule

// ==== logic/tile_controller.sv ====
/*
 * step FSM, tile and row counters, address generation,
 * read issue and outstanding result credit
 */
`timescale 1ns/1ps

module tile_controller #(
  parameter tile_pkg::addr_t IN_BASE  = '0,
  parameter tile_pkg::addr_t W_BASE   = '0,
  parameter tile_pkg::addr_t OUT_BASE = '0
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  tile_pkg::tile_cnt_t tile_s_i,
  input  tile_pkg::tile_cnt_t tile_e_i,
  input  tile_pkg::tile_cnt_t tile_p_i,
  input  logic                inp_ready_i,
  input  logic                weight_ready_i,
  input  logic                inp_valid_i,
  input  logic                weight_valid_i,
  input  logic                res_taken_i,
  input  logic                wr_idle_i,
  output logic                rd_req_o,
  output tile_pkg::addr_t     inp_addr_o,
  output tile_pkg::addr_t     weight_addr_o,
  output logic                calc_en_o,
  output logic                first_inner_tile_o,
  output logic                last_inner_tile_o,
  output tile_pkg::addr_t     res_addr_o,
  output logic                busy_o,
  output logic                done_o,
  output tile_pkg::step_e     step_o
);

  localparam int CntW = $clog2(tile_pkg::FifoDepth + 1);
  localparam tile_pkg::row_cnt_t RowLast = tile_pkg::row_cnt_t'(tile_pkg::M - 1);

  tile_pkg::step_e     step_q, step_d;
  tile_pkg::tile_cnt_t tile_y_q, tile_y_d;
  tile_pkg::tile_cnt_t tile_x_q, tile_x_d;
  tile_pkg::tile_cnt_t k_q, k_d;
  tile_pkg::row_cnt_t  r_q, r_d;
  logic [CntW-1:0]     outst_q, outst_d;
  tile_pkg::tile_cnt_t e_last, p_last, s_last;
  tile_pkg::addr_t     row, col;
  logic                last_slot;
  logic                push;

  assign e_last = tile_e_i - 1'b1;
  assign p_last = tile_p_i - 1'b1;
  assign s_last = tile_s_i - 1'b1;

  assign row = tile_pkg::addr_t'(tile_y_q * tile_pkg::M + r_q);
  assign col = tile_pkg::addr_t'(tile_x_q * tile_pkg::N); // first of the 4 W columns

  assign inp_addr_o    = IN_BASE + row * tile_e_i + k_q;
  assign weight_addr_o = W_BASE + col * tile_e_i + k_q;
  assign res_addr_o    = OUT_BASE + row * tile_p_i + tile_x_q;

  assign first_inner_tile_o = (k_q == '0);
  assign last_inner_tile_o  = (k_q == e_last);
  assign last_slot = last_inner_tile_o && (r_q == RowLast) &&
                     (tile_x_q == p_last) && (tile_y_q == s_last);

  // a last-tile request needs a free result slot
  assign rd_req_o = (step_q == tile_pkg::MatMul) && inp_ready_i && weight_ready_i &&
                    (!last_inner_tile_o || outst_q < CntW'(tile_pkg::FifoDepth));
  assign calc_en_o = (step_q == tile_pkg::MatMul) && inp_valid_i && weight_valid_i;
  assign push      = calc_en_o && last_inner_tile_o;

  assign done_o = (step_q == tile_pkg::Drain) && (outst_q == '0) && wr_idle_i;
  assign busy_o = (step_q != tile_pkg::Idle);
  assign step_o = step_q;

  always_comb begin
    step_d   = step_q;
    tile_y_d = tile_y_q;
    tile_x_d = tile_x_q;
    r_d      = r_q;
    k_d      = k_q;
    outst_d  = outst_q;
    case (step_q)
      tile_pkg::Idle: begin
        if (start_i) begin
          step_d   = tile_pkg::MatMul;
          tile_y_d = '0;
          tile_x_d = '0;
          r_d      = '0;
          k_d      = '0;
        end
      end
      tile_pkg::MatMul: begin
        if (calc_en_o) begin
          if (!last_inner_tile_o) begin
            k_d = k_q + 1'b1;
          end else begin
            k_d = '0;
            r_d = r_q + 1'b1; // wraps after row 3
            if (r_q == RowLast) begin
              if (tile_x_q == p_last) begin
                tile_x_d = '0;
                tile_y_d = tile_y_q + 1'b1;
              end else begin
                tile_x_d = tile_x_q + 1'b1;
              end
            end
          end
          if (last_slot) begin
            step_d = tile_pkg::Drain;
          end
        end
      end
      tile_pkg::Drain: begin
        if (done_o) begin
          step_d = tile_pkg::Idle;
        end
      end
      default: step_d = tile_pkg::Idle;
    endcase
    if (push && !res_taken_i) begin
      outst_d = outst_q + 1'b1;
    end else if (res_taken_i && !push) begin
      outst_d = outst_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_q   <= tile_pkg::Idle;
      tile_y_q <= '0;
      tile_x_q <= '0;
      r_q      <= '0;
      k_q      <= '0;
      outst_q  <= '0;
    end else begin
      step_q   <= step_d;
      tile_y_q <= tile_y_d;
      tile_x_q <= tile_x_d;
      r_q      <= r_d;
      k_q      <= k_d;
      outst_q  <= outst_d;
    end
  end

endmodule

// ==== logic/dot_engine.sv ====
/*
 * four-lane int8 multiply-accumulate with shift, saturation and result register
 */
`timescale 1ns/1ps

module dot_engine (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                calc_en_i,
  input  logic                                first_inner_tile_i,
  input  logic                                last_inner_tile_i,
  input  tile_pkg::shift_t                    shift_i,
  input  tile_pkg::addr_t                     res_addr_i,
  input  tile_pkg::word_t                     inp_i,
  input  tile_pkg::word_t [tile_pkg::N-1:0]   weight_i,
  output logic                                res_valid_o,
  output tile_pkg::word_t                     res_data_o,
  output tile_pkg::addr_t                     res_addr_o
);

  tile_pkg::acc_t [tile_pkg::N-1:0] acc_q, acc_d;
  tile_pkg::word_t                  res_d, res_q;
  tile_pkg::addr_t                  addr_q;
  logic                             valid_q;

  // signed byte dot product of two words
  function automatic tile_pkg::acc_t lane_dot(tile_pkg::word_t a, tile_pkg::word_t b);
    tile_pkg::acc_t sum;
    sum = '0;
    for (int i = 0; i < tile_pkg::N; i++) begin
      sum = sum + $signed(a[8*i +: 8]) * $signed(b[8*i +: 8]);
    end
    return sum;
  endfunction

  function automatic logic [7:0] requant(tile_pkg::acc_t acc, tile_pkg::shift_t sh);
    tile_pkg::acc_t v;
    v = acc >>> sh; // arithmetic
    if (v > 127) begin
      return 8'h7f;
    end else if (v < -128) begin
      return 8'h80;
    end
    return v[7:0];
  endfunction

  always_comb begin
    for (int j = 0; j < tile_pkg::N; j++) begin
      acc_d[j] = first_inner_tile_i ? lane_dot(inp_i, weight_i[j])
                                    : acc_q[j] + lane_dot(inp_i, weight_i[j]);
      res_d[8*j +: 8] = requant(acc_d[j], shift_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (calc_en_i) begin
      acc_q <= acc_d;
      if (last_inner_tile_i) begin
        res_q  <= res_d;
        addr_q <= res_addr_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= calc_en_i && last_inner_tile_i;
    end
  end

  assign res_valid_o = valid_q;
  assign res_data_o  = res_q;
  assign res_addr_o  = addr_q;

endmodule

// ==== logic/result_writer.sv ====
/*
 * small result queue drained by Wishbone writes
 */
`timescale 1ns/1ps

module result_writer (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            res_valid_i,
  input  tile_pkg::word_t res_data_i,
  input  tile_pkg::addr_t res_addr_i,
  input  logic            wb_ack_i,
  output logic            res_taken_o,
  output logic            idle_o,
  output logic            wb_cyc_o,
  output logic            wb_stb_o,
  output logic            wb_we_o,
  output tile_pkg::addr_t wb_adr_o,
  output tile_pkg::word_t wb_dat_o
);

  localparam int PtrW = $clog2(tile_pkg::FifoDepth);
  localparam int CntW = $clog2(tile_pkg::FifoDepth + 1);

  tile_pkg::word_t dat_mem [tile_pkg::FifoDepth];
  tile_pkg::addr_t adr_mem [tile_pkg::FifoDepth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            cyc_q;
  logic            pop;

  assign pop = cyc_q && wb_ack_i;

  always_ff @(posedge clk_i) begin
    if (res_valid_i) begin
      dat_mem[wr_ptr_q] <= res_data_i;
      adr_mem[wr_ptr_q] <= res_addr_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      cyc_q    <= 1'b0;
    end else begin
      if (res_valid_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
        cyc_q    <= 1'b0;
      end else if (cnt_q != '0) begin
        cyc_q <= 1'b1; // head entry
      end
      cnt_q <= cnt_q + CntW'(res_valid_i) - CntW'(pop);
    end
  end

  assign res_taken_o = pop;
  assign idle_o      = !cyc_q && (cnt_q == '0);
  assign wb_cyc_o    = cyc_q;
  assign wb_stb_o    = cyc_q;
  assign wb_we_o     = cyc_q;
  assign wb_adr_o    = adr_mem[rd_ptr_q];
  assign wb_dat_o    = dat_mem[rd_ptr_q];

endmodule

// ==== logic/matmul_top.sv ====
/*
 * matmul engine top: controller, readers, MAC engine, writer and bus arbiter
 */
`timescale 1ns/1ps

module matmul_top #(
  parameter tile_pkg::addr_t IN_BASE  = '0,
  parameter tile_pkg::addr_t W_BASE   = '0,
  parameter tile_pkg::addr_t OUT_BASE = '0
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  tile_pkg::tile_cnt_t tile_s_i,
  input  tile_pkg::tile_cnt_t tile_e_i,
  input  tile_pkg::tile_cnt_t tile_p_i,
  input  tile_pkg::shift_t    shift_i,
  output logic                busy_o,
  output logic                done_o,
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  output logic                wb_we_o,
  output tile_pkg::addr_t     wb_adr_o,
  output tile_pkg::word_t     wb_dat_o,
  input  tile_pkg::word_t     wb_dat_i,
  input  logic                wb_ack_i
);

  logic                             rd_req, calc_en, first_inner, last_inner;
  logic                             inp_ready, inp_valid, weight_ready, weight_valid;
  logic                             res_valid, res_taken, wr_idle;
  tile_pkg::addr_t                  inp_addr, weight_addr, ctl_res_addr, eng_res_addr;
  tile_pkg::word_t [0:0]            inp_data;
  tile_pkg::word_t [tile_pkg::N-1:0] weight_data;
  tile_pkg::word_t                  res_data;

  // bus masters: 0 input, 1 weight, 2 writer
  logic            [2:0]            m_cyc, m_stb, m_we, m_ack;
  tile_pkg::addr_t [2:0]            m_adr;
  tile_pkg::word_t [2:0]            m_wdat, m_rdat;

  assign m_we[1:0]   = 2'b00;
  assign m_wdat[1:0] = '0;

  tile_controller #(
    .IN_BASE(IN_BASE), .W_BASE(W_BASE), .OUT_BASE(OUT_BASE)
  ) u_ctrl (
    .clk_i, .rst_ni, .start_i, .tile_s_i, .tile_e_i, .tile_p_i,
    .inp_ready_i(inp_ready), .weight_ready_i(weight_ready),
    .inp_valid_i(inp_valid), .weight_valid_i(weight_valid),
    .res_taken_i(res_taken), .wr_idle_i(wr_idle),
    .rd_req_o(rd_req), .inp_addr_o(inp_addr), .weight_addr_o(weight_addr),
    .calc_en_o(calc_en), .first_inner_tile_o(first_inner), .last_inner_tile_o(last_inner),
    .res_addr_o(ctl_res_addr), .busy_o, .done_o, .step_o()
  );

  tile_reader #(.WORDS(1)) u_inp_reader (
    .clk_i, .rst_ni, .req_i(rd_req), .addr_i(inp_addr), .stride_i('0),
    .pop_i(calc_en), .ready_o(inp_ready), .data_valid_o(inp_valid), .data_o(inp_data),
    .wb_cyc_o(m_cyc[0]), .wb_stb_o(m_stb[0]), .wb_adr_o(m_adr[0]),
    .wb_dat_i(m_rdat[0]), .wb_ack_i(m_ack[0])
  );

  tile_reader #(.WORDS(tile_pkg::N)) u_weight_reader (
    .clk_i, .rst_ni, .req_i(rd_req), .addr_i(weight_addr), .stride_i(tile_e_i),
    .pop_i(calc_en), .ready_o(weight_ready), .data_valid_o(weight_valid),
    .data_o(weight_data),
    .wb_cyc_o(m_cyc[1]), .wb_stb_o(m_stb[1]), .wb_adr_o(m_adr[1]),
    .wb_dat_i(m_rdat[1]), .wb_ack_i(m_ack[1])
  );

  dot_engine u_engine (
    .clk_i, .rst_ni, .calc_en_i(calc_en), .first_inner_tile_i(first_inner),
    .last_inner_tile_i(last_inner), .shift_i, .res_addr_i(ctl_res_addr),
    .inp_i(inp_data[0]), .weight_i(weight_data),
    .res_valid_o(res_valid), .res_data_o(res_data), .res_addr_o(eng_res_addr)
  );

  result_writer u_writer (
    .clk_i, .rst_ni, .res_valid_i(res_valid), .res_data_i(res_data),
    .res_addr_i(eng_res_addr), .wb_ack_i(m_ack[2]),
    .res_taken_o(res_taken), .idle_o(wr_idle),
    .wb_cyc_o(m_cyc[2]), .wb_stb_o(m_stb[2]), .wb_we_o(m_we[2]),
    .wb_adr_o(m_adr[2]), .wb_dat_o(m_wdat[2])
  );

  wb_arbiter #(.NumMasters(3)) u_arbiter (
    .clk_i, .rst_ni,
    .m_cyc_i(m_cyc), .m_stb_i(m_stb), .m_we_i(m_we), .m_adr_i(m_adr),
    .m_dat_i(m_wdat), .m_dat_o(m_rdat), .m_ack_o(m_ack),
    .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_dat_o, .wb_dat_i, .wb_ack_i
  );

endmodule

// ==== bench/tb_matmul.sv ====
/*
 * testbench for matmul_top: clock, Wishbone memory model with wait states,
 * case file reader, compare tasks and watchdog
 */
`timescale 1ns/1ps

module tb_matmul;

  localparam tile_pkg::addr_t InBase  = 16'h0000;
  localparam tile_pkg::addr_t WBase   = 16'h0100;
  localparam tile_pkg::addr_t OutBase = 16'h0200;
  localparam int MaxCases = 8;
  localparam int PeriodNs = 40;

  logic                clk_i;
  logic                rst_ni;
  logic                start_i;
  tile_pkg::tile_cnt_t tile_s_i;
  tile_pkg::tile_cnt_t tile_e_i;
  tile_pkg::tile_cnt_t tile_p_i;
  tile_pkg::shift_t    shift_i;
  logic                busy_o;
  logic                done_o;
  logic                wb_cyc_o;
  logic                wb_stb_o;
  logic                wb_we_o;
  tile_pkg::addr_t     wb_adr_o;
  tile_pkg::word_t     wb_dat_o;
  tile_pkg::word_t     wb_dat_i;
  logic                wb_ack_i;

  tile_pkg::word_t mem [65536];
  integer          seed = 32'hb9c4f1c6;
  logic            pending;
  int              wait_left;
  int              writes;

  // cases from the input file
  string               case_name [MaxCases];
  tile_pkg::tile_cnt_t case_s [MaxCases];
  tile_pkg::tile_cnt_t case_e [MaxCases];
  tile_pkg::tile_cnt_t case_p [MaxCases];
  tile_pkg::shift_t    case_shift [MaxCases];
  int                  load_first [MaxCases];
  int                  load_num [MaxCases];
  int                  exp_first [MaxCases];
  int                  exp_num [MaxCases];
  int                  n_cases;
  tile_pkg::addr_t     load_adr [$];
  tile_pkg::word_t     load_dat [$];
  tile_pkg::addr_t     exp_adr [$];
  tile_pkg::word_t     exp_dat [$];

  int     errors;
  int     n_ok;
  int     n_bad;
  logic   hung;
  longint budget_cycles;
  longint timeout_ns;

  matmul_top #(
    .IN_BASE(InBase), .W_BASE(WBase), .OUT_BASE(OutBase)
  ) u_dut (
    .clk_i, .rst_ni, .start_i, .tile_s_i, .tile_e_i, .tile_p_i, .shift_i,
    .busy_o, .done_o, .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_dat_o,
    .wb_dat_i, .wb_ack_i
  );

  always #(PeriodNs / 2) clk_i = ~clk_i;

  // memory model, 0 to 3 wait cycles per transfer
  always @(posedge clk_i) begin
    #2;
    if (wb_ack_i) begin
      wb_ack_i = 1'b0; // master drops cyc after ack
    end else if (wb_cyc_o && wb_stb_o) begin
      if (!pending) begin
        pending   = 1'b1;
        wait_left = $unsigned($random(seed)) % 4;
      end
      if (wait_left == 0) begin
        pending  = 1'b0;
        wb_ack_i = 1'b1;
        if (wb_we_o) begin
          mem[wb_adr_o] = wb_dat_o;
          writes++;
          if (wb_adr_o < OutBase) begin
            $display("ERROR %0t: write to %h inside the input or weight region",
                     $time, wb_adr_o);
            errors++;
          end
        end else begin
          wb_dat_i = mem[wb_adr_o];
        end
      end else begin
        wait_left--;
      end
    end
  end

  task automatic check_word(input tile_pkg::addr_t adr, input tile_pkg::word_t got,
                            input tile_pkg::word_t exp);
    if (got !== exp) begin
      $display("ERROR %0t: word at %h is %h, expected %h", $time, adr, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input tile_pkg::tile_cnt_t got, input tile_pkg::tile_cnt_t exp);
    if (got !== exp) begin
      $display("ERROR %0t: %0d result writes seen, expected %0d", $time, got, exp);
      errors++;
    end
  endtask

  task automatic read_cases();
    int    fd;
    int    n;
    int    target;
    int    total;
    int    v [8];
    string line;
    string kw;
    target = 0;
    total  = 0;
    fd = $fopen("bench/matmul_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the input file bench/matmul_input.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n == 0 || line.len() < 2 || line[0] == "#") begin
          continue;
        end
        n = $sscanf(line, "%s", kw);
        if (kw == "case" && n_cases < MaxCases) begin
          n = $sscanf(line, "%s %s %d %d %d %d", kw, case_name[n_cases], case_s[n_cases],
                      case_e[n_cases], case_p[n_cases], case_shift[n_cases]);
          load_first[n_cases] = load_adr.size();
          exp_first[n_cases]  = exp_adr.size();
          n_cases++;
          target = 0;
        end else if (kw == "load" && n_cases > 0) begin
          n = $sscanf(line, "%s %d", kw, load_num[n_cases-1]);
          total += load_num[n_cases-1];
          target = 1;
        end else if (kw == "expect" && n_cases > 0) begin
          n = $sscanf(line, "%s %d", kw, exp_num[n_cases-1]);
          total += exp_num[n_cases-1];
          target = 2;
        end else begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                      v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
          for (int i = 0; i + 1 < n; i += 2) begin
            if (target == 1) begin
              load_adr.push_back(tile_pkg::addr_t'(v[i]));
              load_dat.push_back(tile_pkg::word_t'(v[i+1]));
            end else if (target == 2) begin
              exp_adr.push_back(tile_pkg::addr_t'(v[i]));
              exp_dat.push_back(tile_pkg::word_t'(v[i+1]));
            end
          end
        end
      end
      $fclose(fd);
      if (total != load_adr.size() + exp_adr.size()) begin
        $display("input file counts do not match the address/data pairs it holds");
        errors++;
      end
    end
  endtask

  task automatic run_case(input int c);
    int   first_err;
    int   limit;
    int   cycles;
    logic busy_bad;
    first_err = errors;
    busy_bad  = 1'b0;
    limit = int'(case_s[c]) * int'(case_p[c]) * tile_pkg::M * int'(case_e[c]) * 6 * 5 * 2
            + 100;
    for (int a = 0; a < 65536; a++) begin
      mem[a] = {~a[15:0], a[15:0]};
    end
    for (int i = 0; i < load_num[c]; i++) begin
      mem[load_adr[load_first[c] + i]] = load_dat[load_first[c] + i];
    end
    writes = 0;
    @(posedge clk_i);
    #2;
    tile_s_i = case_s[c];
    tile_e_i = case_e[c];
    tile_p_i = case_p[c];
    shift_i  = case_shift[c];
    start_i  = 1'b1;
    @(posedge clk_i);
    #2;
    start_i = 1'b0;
    cycles  = 0;
    @(negedge clk_i);
    while (!done_o && cycles < limit) begin
      if (!busy_o && !busy_bad) begin
        $display("busy_o low during run of test %0s", case_name[c]);
        errors++;
        busy_bad = 1'b1;
      end
      cycles++;
      @(negedge clk_i);
    end
    if (!done_o) begin
      $display("done_o never pulsed in test %0s", case_name[c]);
      errors++;
      hung = 1'b1;
    end else begin
      @(negedge clk_i);
      if (done_o) begin
        $display("done_o stayed high for more than one cycle in test %0s", case_name[c]);
        errors++;
      end
      if (busy_o) begin
        $display("busy_o still high after done_o in test %0s", case_name[c]);
        errors++;
      end
      check_count(tile_pkg::tile_cnt_t'(writes),
                  tile_pkg::tile_cnt_t'(int'(case_s[c]) * tile_pkg::M * int'(case_p[c])));
      for (int i = exp_first[c]; i < exp_first[c] + exp_num[c]; i++) begin
        check_word(exp_adr[i], mem[exp_adr[i]], exp_dat[i]);
      end
    end
    if (errors == first_err) begin
      $display("test %0s: ok", case_name[c]);
      n_ok++;
    end else begin
      $display("test %0s: %0d errors", case_name[c], errors - first_err);
      n_bad++;
    end
  endtask

  initial begin
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    start_i   = 1'b0;
    tile_s_i  = '0;
    tile_e_i  = '0;
    tile_p_i  = '0;
    shift_i   = '0;
    wb_dat_i  = '0;
    wb_ack_i  = 1'b0;
    pending   = 1'b0;
    wait_left = 0;
    writes    = 0;
    errors    = 0;
    n_ok      = 0;
    n_bad     = 0;
    n_cases   = 0;
    hung      = 1'b0;
    read_cases();
    budget_cycles = 0;
    for (int c = 0; c < n_cases; c++) begin
      budget_cycles += longint'(case_s[c]) * case_p[c] * tile_pkg::M * case_e[c] * 6 * 5;
    end
    timeout_ns = (budget_cycles * 2 + 200 * (n_cases + 1)) * PeriodNs;
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    for (int c = 0; c < n_cases && !hung; c++) begin
      run_case(c);
    end
    $display("%0d tests ok, %0d tests with errors", n_ok, n_bad);
    if (errors == 0 && n_bad == 0 && n_cases > 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // ends a run that outlives the sum of the case budgets
  initial begin
    wait (timeout_ns > 0);
    #(timeout_ns);
    $display("watchdog expired before all tests finished");
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== bench/matmul_input.txt ====
# case <name> <tile_s> <tile_e> <tile_p> <shift>, then "load <n>" and "expect <n>",
# each followed by n hex address/data pairs, up to four pairs per line
case single 1 1 1 0
load 8
0000 04030201 0001 010200ff 0002 281e140a 0003 0807fafb
0100 01010101 0101 ff000001 0102 0003ff02 0103 02000000
expect 4
0200 0809fd0a 0201 0204fe02 0202 505ae264 0203 1011f304
case accumulate 1 3 1 0
load 24
0000 04030201 0001 08070605 0002 01010101 0003 ffffffff
0004 02020202 0005 fd000003 0006 14141414 0007 14141414
0008 14141414 0009 00000000 000a e2e2e2e2 000b f6f6f6f6
0100 01010101 0101 01010101 0102 01010101 0103 00000001
0104 00000000 0105 00000000 0106 00000000 0107 00000000
0108 02020202 0109 ffffffff 010a 01010101 010b 00000000
expect 4
0200 10080128 0201 0c00ff04 0202 007f147f 0203 88b00080
case multitile 2 1 2 0
load 16
0000 04030201 0001 08070605 0002 fcfdfeff 0003 00000064
0004 09000000 0005 00000080 0006 03030303 0007 40302010
0100 00000001 0101 00000100 0102 00010000 0103 01000000
0104 01010101 0105 000000ff 0106 ff000000 0107 00000002
expect 16
0200 04030201 0201 02fcff0a 0202 08070605 0203 0af8fb1a
0204 fcfdfeff 0205 fe0401f6 0206 00000064 0207 7f009c64
0208 09000000 0209 00f70009 020a 00000080 020b 80007f80
020c 03030303 020d 06fdfd0c 020e 40302010 020f 20c0f07f
case requant 1 1 1 4
load 8
0000 7f7f7f7f 0001 000000ef 0002 00000020 0003 000001f0
0100 7f7f7f7f 0101 80808080 0102 00000001 0103 000000ff
expect 4
0200 f807807f 0201 01fe7f80 0202 fe02807f 0203 01ff7888

// ==== sources.f ====
common/tile_pkg.sv
logic/wb_arbiter.sv
fetch/tile_reader.sv
logic/tile_controller.sv
logic/dot_engine.sv
logic/result_writer.sv
logic/matmul_top.sv
bench/tb_matmul.sv
